/* Makefile */
# Verilator flow for the RV32I core
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TOP       ?= tbFemtoCore
RTL_TOP   ?= femtoCore
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* aluUnit.sv */
/* aluUnit
   Combinational RV32I ALU with shared subtract-compare, one shifter and branch predicate
*/
module aluUnit (
   execIf.alu              ex,
   output femtoPkg::word_t aluOut,
   output femtoPkg::word_t aluPlus,
   output logic            takeBranch
);
   import femtoPkg::*;

   logic        isAluReg;
   logic        isBranch;
   logic [7:0]  funct3Is;   // One-hot funct3
   word_t       iImm;
   word_t       aluIn1;
   word_t       aluIn2;
   logic [32:0] aluMinus;   // Borrow out in bit 32
   logic        lt;
   logic        ltu;
   logic        eq;
   word_t       shifterIn;
   logic [32:0] shiftExt;   // Extra MSB carries the SRA sign
   word_t       shifter;
   word_t       leftShift;

   function automatic word_t bitReverse(input word_t v);
      word_t r;
      for (int i = 0; i < xlen; i++) begin
         r[i] = v[xlen-1-i];
      end
      return r;
   endfunction

   always_comb begin
      isAluReg = opcode_t'(ex.instr[6:2]) == aluReg;
      isBranch = opcode_t'(ex.instr[6:2]) == branch;
      funct3Is = 8'b0000_0001 << ex.instr[14:12];
      iImm     = {{21{ex.instr[31]}}, ex.instr[30:20]};

      aluIn1 = ex.rs1Val;
      aluIn2 = (isAluReg || isBranch) ? ex.rs2Val : iImm;  // Loads and JALR take Iimm

      aluPlus  = aluIn1 + aluIn2;                      // Also the JALR target
      aluMinus = {1'b0, aluIn1} - {1'b0, aluIn2};
      ltu      = aluMinus[32];
      lt       = (aluIn1[31] ^ aluIn2[31]) ? aluIn1[31] : aluMinus[32];
      eq       = aluMinus[31:0] == '0;

      // Left shift = reverse, shift right, reverse back
      shifterIn = funct3Is[1] ? bitReverse(aluIn1) : aluIn1;
      shiftExt  = $signed({ex.instr[30] & aluIn1[31], shifterIn}) >>> aluIn2[4:0];
      shifter   = shiftExt[31:0];
      leftShift = bitReverse(shifter);

      // instr[30] picks SUB only for register ops, instr[5] tells them apart from ADDI
      aluOut = (funct3Is[0] ? ((ex.instr[30] && ex.instr[5]) ? aluMinus[31:0] : aluPlus)
                            : '0)
             | (funct3Is[1] ? leftShift             : '0)
             | (funct3Is[2] ? word_t'(lt)           : '0)  // SLT
             | (funct3Is[3] ? word_t'(ltu)          : '0)  // SLTU
             | (funct3Is[4] ? (aluIn1 ^ aluIn2)     : '0)
             | (funct3Is[5] ? shifter               : '0)  // SRL, SRA
             | (funct3Is[6] ? (aluIn1 | aluIn2)     : '0)
             | (funct3Is[7] ? (aluIn1 & aluIn2)     : '0);

      // funct3 2 and 3 are not branches
      takeBranch = isBranch & ((funct3Is[0] &  eq)    // BEQ
                             | (funct3Is[1] & ~eq)    // BNE
                             | (funct3Is[4] &  lt)    // BLT
                             | (funct3Is[5] & ~lt)    // BGE
                             | (funct3Is[6] &  ltu)   // BLTU
                             | (funct3Is[7] & ~ltu)); // BGEU
   end

endmodule

/* coreControl.sv */
/* coreControl
   One-hot FSM, PC, instruction and operand latch, decode, next PC and write-back select
*/
module coreControl (
   input  logic                             clk,
   input  logic                             reset,
   input  femtoPkg::word_t                  memRdata,
   input  logic                             memRbusy,
   input  logic                             memWbusy,
   input  femtoPkg::word_t                  aluOut,
   input  femtoPkg::word_t                  aluPlus,
   input  logic                             takeBranch,
   input  femtoPkg::word_t                  loadData,
   input  femtoPkg::word_t                  rs1Rd,
   input  femtoPkg::word_t                  rs2Rd,
   output logic                             memRstrb,
   output logic                             storeEn,
   output logic                             fetchPhase,
   output logic [femtoPkg::regIdxWidth-1:0] rs1Idx,
   output logic [femtoPkg::regIdxWidth-1:0] rs2Idx,
   output logic [femtoPkg::regIdxWidth-1:0] rdIdx,
   output logic                             regWrite,
   output femtoPkg::word_t                  regWdata,
   execIf.ctrl                              ex
);
   import femtoPkg::*;

   coreState_t state;
   opcode_t    opcode;
   logic       isLoad, isStore, isBranch, isJal, isJalr, isLui, isAuipc, isSystem;
   logic       instrReady;  // Instruction word valid this cycle
   logic       memDone;     // Both busy lines low
   word_t      uImm;
   word_t      jImm;
   word_t      bImm;
   addr_t      pcPlus4;
   addr_t      pcPlusImm;   // Shared by branches, JAL and AUIPC
   addr_t      pcNext;

   // Decode from the latched instruction
   always_comb begin
      opcode   = opcode_t'(ex.instr[6:2]);
      isLoad   = opcode == load;
      isStore  = opcode == store;
      isBranch = opcode == branch;
      isJal    = opcode == jal;
      isJalr   = opcode == jalr;
      isLui    = opcode == lui;
      isAuipc  = opcode == auipc;
      isSystem = opcode == system;

      uImm = {ex.instr[31:12], 12'b0};
      jImm = {{12{ex.instr[31]}}, ex.instr[19:12], ex.instr[20], ex.instr[30:21], 1'b0};
      bImm = {{20{ex.instr[31]}}, ex.instr[7], ex.instr[30:25], ex.instr[11:8], 1'b0};

      pcPlus4   = ex.pc + addr_t'(4);
      pcPlusImm = addr_t'(word_t'(ex.pc) + (isJal ? jImm : isAuipc ? uImm : bImm));

      if (isJalr) begin
         pcNext = {aluPlus[addrWidth-1:1], 1'b0};  // Bit 0 cleared
      end else if (isJal || takeBranch) begin
         pcNext = pcPlusImm;
      end else begin
         pcNext = pcPlus4;
      end
   end

   // Write-back value, upper address bits read as zero
   always_comb begin
      if (isLui) begin
         regWdata = uImm;
      end else if (isAuipc) begin
         regWdata = word_t'(pcPlusImm);
      end else if (isJal || isJalr) begin
         regWdata = word_t'(pcPlus4);  // Link address
      end else if (isLoad) begin
         regWdata = loadData;
      end else begin
         regWdata = aluOut;
      end
   end

   always_comb begin
      instrReady = (state == waitInstr) && !memRbusy;
      memDone    = !memRbusy && !memWbusy;
      fetchPhase = (state == fetchInstr) || (state == waitInstr);
      memRstrb   = (state == fetchInstr) || ((state == execute) && isLoad);
      storeEn    = (state == execute) && isStore;

      // Register indices come straight off the bus while decoding
      rs1Idx = memRdata[19:15];
      rs2Idx = memRdata[24:20];
      rdIdx  = ex.instr[11:7];

      // Loads write when the wait ends, SYSTEM writes nothing
      regWrite = ((state == execute) && !(isBranch || isStore || isLoad || isSystem))
              || ((state == waitMem) && isLoad && memDone);
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         state    <= waitMem;         // Let a pending write drain first
         ex.pc    <= resetAddr;
         ex.instr <= nopInstr[31:2];
      end else begin
         case (state)
            fetchInstr: state <= waitInstr;
            waitInstr: begin
               if (instrReady) begin
                  ex.instr <= memRdata[31:2];
                  state    <= execute;
               end
            end
            execute: begin
               ex.pc <= pcNext;
               state <= (isLoad || isStore) ? waitMem : fetchInstr;
            end
            waitMem: begin
               if (memDone) state <= fetchInstr;
            end
            default: state <= waitMem;  // Illegal encoding recovers
         endcase
      end
   end

   // Operand latch, no reset
   always_ff @(posedge clk) begin
      if (instrReady) begin
         ex.rs1Val <= rs1Rd;
         ex.rs2Val <= rs2Rd;
      end
   end

endmodule

/* execIf.sv */
/* execIf
   Latched instruction, operands and PC, from the controller to the execute units
*/
interface execIf #(
   parameter int dataWidth = femtoPkg::xlen,
   parameter int pcWidth   = femtoPkg::addrWidth
);

   logic [dataWidth-1:2] instr;   // Instruction bits 1:0 are always 2'b11 in RV32I
   logic [dataWidth-1:0] rs1Val;  // Operands read at decode
   logic [dataWidth-1:0] rs2Val;
   logic [pcWidth-1:0]   pc;      // Address of the current instruction

   // Controller owns all of it
   modport ctrl (
      output instr, rs1Val, rs2Val, pc
   );

   // ALU needs no PC
   modport alu (
      input instr, rs1Val, rs2Val
   );

   // Load/store unit also drives the fetch address
   modport lsu (
      input instr, rs1Val, rs2Val, pc
   );

endinterface

/* femtoCore.sv */
/* femtoCore
   Multicycle RV32I core, controller and execute units on a simple memory bus
*/
module femtoCore (
   input  logic            clk,
   input  logic            reset,
   input  femtoPkg::word_t memRdata,
   input  logic            memRbusy,
   input  logic            memWbusy,
   output femtoPkg::word_t memAddr,
   output femtoPkg::word_t memWdata,
   output logic [3:0]      memWmask,
   output logic            memRstrb
);
   import femtoPkg::*;

   word_t                  aluOut;
   word_t                  aluPlus;
   word_t                  loadData;
   word_t                  rs1Rd;
   word_t                  rs2Rd;
   word_t                  regWdata;
   logic                   takeBranch;
   logic                   storeEn;
   logic                   fetchPhase;
   logic                   regWrite;
   logic [regIdxWidth-1:0] rs1Idx;
   logic [regIdxWidth-1:0] rs2Idx;
   logic [regIdxWidth-1:0] rdIdx;

   execIf ex0 ();  // Instruction and operands to the execute units

   coreControl ctrl0 (
      .clk        (clk),
      .reset      (reset),
      .memRdata   (memRdata),
      .memRbusy   (memRbusy),
      .memWbusy   (memWbusy),
      .aluOut     (aluOut),
      .aluPlus    (aluPlus),
      .takeBranch (takeBranch),
      .loadData   (loadData),
      .rs1Rd      (rs1Rd),
      .rs2Rd      (rs2Rd),
      .memRstrb   (memRstrb),
      .storeEn    (storeEn),
      .fetchPhase (fetchPhase),
      .rs1Idx     (rs1Idx),
      .rs2Idx     (rs2Idx),
      .rdIdx      (rdIdx),
      .regWrite   (regWrite),
      .regWdata   (regWdata),
      .ex         (ex0)
   );

   regFile regs0 (
      .clk      (clk),
      .rs1Idx   (rs1Idx),
      .rs2Idx   (rs2Idx),
      .rdIdx    (rdIdx),
      .regWrite (regWrite),
      .regWdata (regWdata),
      .rs1Rd    (rs1Rd),
      .rs2Rd    (rs2Rd)
   );

   aluUnit alu0 (
      .ex         (ex0),
      .aluOut     (aluOut),
      .aluPlus    (aluPlus),
      .takeBranch (takeBranch)
   );

   loadStore lsu0 (
      .ex         (ex0),
      .fetchPhase (fetchPhase),
      .storeEn    (storeEn),
      .memRdata   (memRdata),
      .memAddr    (memAddr),
      .memWdata   (memWdata),
      .memWmask   (memWmask),
      .loadData   (loadData)
   );

endmodule

/* femtoPkg.sv */
/* femtoPkg
   Shared widths, opcode and state encodings and the reset address of the RV32I core
*/
package femtoPkg;

   localparam int xlen        = 32;  // Data word width
   localparam int addrWidth   = 24;  // Internal address width, upper bus bits read as zero
   localparam int regIdxWidth = 5;   // 32 integer registers

   typedef logic [xlen-1:0]      word_t;
   typedef logic [addrWidth-1:0] addr_t;

   localparam addr_t resetAddr = '0;  // First fetch address

   // Canonical NOP, addi x0, x0, 0
   // Loaded into the instruction latch so that nothing decodes as a load after reset
   localparam word_t nopInstr = 32'h0000_0013;

   // Major opcodes, instruction bits 6 to 2
   typedef enum logic [4:0] {
      load   = 5'b00000,  // rd <- mem[rs1 + Iimm]
      aluImm = 5'b00100,  // rd <- rs1 op Iimm
      auipc  = 5'b00101,  // rd <- PC + Uimm
      store  = 5'b01000,  // mem[rs1 + Simm] <- rs2
      aluReg = 5'b01100,  // rd <- rs1 op rs2
      lui    = 5'b01101,  // rd <- Uimm
      branch = 5'b11000,  // if (rs1 op rs2) PC <- PC + Bimm
      jalr   = 5'b11001,  // rd <- PC + 4, PC <- rs1 + Iimm
      jal    = 5'b11011,  // rd <- PC + 4, PC <- PC + Jimm
      system = 5'b11100   // Executes as a no-op
   } opcode_t;

   // One-hot controller states
   typedef enum logic [3:0] {
      fetchInstr = 4'b0001,  // Raise read strobe at PC
      waitInstr  = 4'b0010,  // Wait for instruction word, latch operands
      execute    = 4'b0100,  // Write result, update PC, start memory access
      waitMem    = 4'b1000   // Wait for load data or write acceptance
   } coreState_t;

endpackage

/* loadStore.sv */
/* loadStore
   Access address, memory address mux, store lane steering and mask, load alignment
*/
module loadStore (
   execIf.lsu              ex,
   input  logic            fetchPhase,
   input  logic            storeEn,
   input  femtoPkg::word_t memRdata,
   output femtoPkg::word_t memAddr,
   output femtoPkg::word_t memWdata,
   output logic [3:0]      memWmask,
   output femtoPkg::word_t loadData
);
   import femtoPkg::*;

   word_t       iImm;
   word_t       sImm;
   addr_t       lsAddr;      // Byte address of the load or store
   logic        byteAccess;
   logic        halfAccess;
   logic [3:0]  storeMask;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   always_comb begin
      iImm = {{21{ex.instr[31]}}, ex.instr[30:20]};
      sImm = {{21{ex.instr[31]}}, ex.instr[30:25], ex.instr[11:7]};

      // instr[5] is set for stores, clear for loads
      lsAddr = addr_t'(ex.rs1Val + (ex.instr[5] ? sImm : iImm));

      byteAccess = ex.instr[13:12] == 2'b00;
      halfAccess = ex.instr[13:12] == 2'b01;

      // PC during fetch, else the data access
      memAddr = fetchPhase ? word_t'({ex.pc[addrWidth-1:2], 2'b00}) : word_t'(lsAddr);
   end

   // Store side
   always_comb begin
      if (byteAccess) begin
         memWdata  = {4{ex.rs2Val[7:0]}};     // Byte on every lane
         storeMask = 4'b0001 << lsAddr[1:0];
      end else if (halfAccess) begin
         memWdata  = {2{ex.rs2Val[15:0]}};    // Halfword on both halves
         storeMask = lsAddr[1] ? 4'b1100 : 4'b0011;
      end else begin
         memWdata  = ex.rs2Val;
         storeMask = 4'b1111;
      end
      memWmask = storeEn ? storeMask : 4'b0000;  // Only in the execute cycle of a store
   end

   // Load side
   always_comb begin
      loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
      loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];

      // funct3[2] set means LBU/LHU
      loadSign = ~ex.instr[14] & (byteAccess ? loadByte[7] : loadHalf[15]);

      if (byteAccess) begin
         loadData = {{24{loadSign}}, loadByte};
      end else if (halfAccess) begin
         loadData = {{16{loadSign}}, loadHalf};
      end else begin
         loadData = memRdata;
      end
   end

endmodule

/* regFile.sv */
/* regFile
   32 x 32-bit integer registers, two combinational reads, one clocked write, x0 reads zero
*/
module regFile (
   input  logic                             clk,
   input  logic [femtoPkg::regIdxWidth-1:0] rs1Idx,
   input  logic [femtoPkg::regIdxWidth-1:0] rs2Idx,
   input  logic [femtoPkg::regIdxWidth-1:0] rdIdx,
   input  logic                             regWrite,
   input  femtoPkg::word_t                  regWdata,
   output femtoPkg::word_t                  rs1Rd,
   output femtoPkg::word_t                  rs2Rd
);
   import femtoPkg::*;

   word_t regs [2**regIdxWidth];  // Plain storage, no reset

   // Index 0 is never written
   always_ff @(posedge clk) begin
      if (regWrite && rdIdx != '0) begin
         regs[rdIdx] <= regWdata;
      end
   end

   // x0 forced to zero on read since its entry is never initialized
   always_comb begin
      rs1Rd = (rs1Idx == '0) ? '0 : regs[rs1Idx];
      rs2Rd = (rs2Idx == '0) ? '0 : regs[rs2Idx];
   end

endmodule

/* tbFemtoCore.sv */
/* tbFemtoCore
   Random RV32I program against the core, with a busy-stalling memory and an ISA model
*/
module tbFemtoCore;
   timeunit 1ns;
   timeprecision 100ps;
   import femtoPkg::*;

   localparam int memWords = 512;   // 0x000-0x3FF program, 0x400-0x7FF data
   localparam int dataBase = 256;   // First data word
   localparam int randInstrs = 180;

   logic clk, reset, memRbusy, memWbusy, memRstrb;
   word_t memRdata, memAddr, memWdata;
   logic [3:0] memWmask;

   word_t tbMem [memWords];         // Memory seen by the DUT
   word_t modelMem [memWords];      // ISA model memory
   word_t mRegs [32];
   word_t mPc, endPc, lcgState;
   word_t loadAddrExp, storeAddrExp, storeDataExp;
   logic [3:0] storeMaskExp;
   logic loadPending, storePending, done;
   int rdLeft, wrLeft, progIdx;

   femtoCore dut0 (.*);

   function automatic word_t rnd();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState ^ (lcgState >> 15);
   endfunction

   task automatic reportFail(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic checkEq(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         reportFail($sformatf("mismatch %s: got %h expected %h", name, got, exp));
      end
   endtask

   task automatic emit(input word_t w);
      tbMem[progIdx] = w;
      progIdx++;
   endtask

   // Instruction encoders
   function automatic word_t encI(word_t imm, word_t rs1, word_t f3, word_t rd, logic [6:0] op);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
   endfunction
   function automatic word_t encR(logic f7, word_t rs2, word_t rs1, word_t f3, word_t rd);
      return {1'b0, f7, 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
   endfunction
   function automatic word_t encS(word_t imm, word_t rs2, word_t rs1, word_t f3);
      return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
   endfunction
   function automatic word_t encB(word_t imm, word_t rs2, word_t rs1, word_t f3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
   endfunction
   function automatic word_t encJ(word_t imm, word_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
   endfunction

   task automatic buildProgram();
      word_t f3, off, imm;
      int    kind;
      int    brF3 [6] = '{0, 1, 4, 5, 6, 7};
      int    ldF3 [5] = '{0, 1, 2, 4, 5};
      for (int i = 0; i < memWords; i++) begin
         tbMem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_1234;  // Fill depends on whole address
      end
      progIdx = 0;
      emit(encI(32'h400, 0, 0, 31, 7'b0010011));   // x31 = data base, never overwritten
      for (int r = 1; r <= 30; r++) emit(encI(rnd(), 0, 0, r, 7'b0010011));
      for (int n = 0; n < randInstrs; n++) begin
         kind = rnd() % 11;
         case (kind)
            0: emit({rnd() & 32'hffff_f000} | ((rnd() % 30) << 7) | 7'b0110111);  // LUI
            1: emit({rnd() & 32'hffff_f000} | ((rnd() % 30) << 7) | 7'b0010111);  // AUIPC
            2: begin
               f3  = rnd() % 8;
               imm = rnd();
               if (f3 == 1) imm = imm & 32'h1f;              // SLLI
               if (f3 == 5) imm = imm & 32'h41f;             // SRLI or SRAI
               emit(encI(imm, rnd() % 32, f3, rnd() % 30, 7'b0010011));
            end
            3, 4: begin
               f3 = rnd() % 8;
               emit(encR((f3 == 0 || f3 == 5) ? rnd() % 2 : 0, rnd() % 32, rnd() % 32, f3,
                         rnd() % 30));
            end
            5: emit(encB(4 * (1 + rnd() % 3), rnd() % 32, rnd() % 32, brF3[rnd() % 6]));
            6: begin
               f3  = ldF3[rnd() % 5];
               off = rnd() % 1024;
               off = (f3[1:0] == 2) ? off & ~32'h3 : (f3[1:0] == 1) ? off & ~32'h1 : off;
               emit(encI(off, 31, f3, 1 + rnd() % 29, 7'b0000011));
            end
            7: begin
               f3  = rnd() % 3;
               off = rnd() % 1024;
               off = (f3 == 2) ? off & ~32'h3 : (f3 == 1) ? off & ~32'h1 : off;
               emit(encS(off, rnd() % 32, 31, f3));
            end
            8: emit(encJ(8, rnd() % 30));                    // Skip one instruction
            9: begin
               imm = progIdx * 4 + 9 - 32'h400;              // Odd offset from x31, bit 0 dropped
               emit(encI(imm, 31, 0, rnd() % 30, 7'b1100111)); // Lands past one instruction
            end
            default: emit(32'h0000_0073);                     // SYSTEM as no-op
         endcase
      end
      repeat (3) emit(nopInstr);                             // Landing pad for skips
      endPc = progIdx * 4;
      emit(encJ(0, 0));                                      // Self-loop ends the run
      modelMem = tbMem;
   endtask

   // Reference execution of one instruction at mPc
   task automatic stepModel();
      word_t w, a, b, iImm, res, addr, lw, nextPc;
      logic [4:0] rd;
      logic [2:0] f3;
      logic take;
      int sh;
      w = modelMem[mPc[10:2]];
      rd = w[11:7];
      f3 = w[14:12];
      a = mRegs[w[19:15]];
      b = mRegs[w[24:20]];
      iImm = {{20{w[31]}}, w[31:20]};
      nextPc = mPc + 4;
      case (w[6:0])
         7'b0110111: mRegs[rd] = {w[31:12], 12'b0};
         // AUIPC keeps only the internal address bits
         7'b0010111: mRegs[rd] = (mPc + {w[31:12], 12'b0}) & ((32'd1 << addrWidth) - 1);
         7'b1101111: begin
            mRegs[rd] = mPc + 4;
            nextPc = mPc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
         end
         7'b1100111: begin
            nextPc = (a + iImm) & ~32'h1;
            mRegs[rd] = mPc + 4;
         end
         7'b1100011: begin
            case (f3)
               0: take = a == b;
               1: take = a != b;
               4: take = $signed(a) < $signed(b);
               5: take = $signed(a) >= $signed(b);
               6: take = a < b;
               default: take = a >= b;
            endcase
            if (take) nextPc = mPc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
         end
         7'b0010011, 7'b0110011: begin
            if (w[5] == 1'b0) b = iImm;                      // Immediate form
            sh = b[4:0];
            case (f3)
               0: res = (w[5] && w[30]) ? a - b : a + b;
               1: res = a << sh;
               2: res = word_t'($signed(a) < $signed(b));
               3: res = word_t'(a < b);
               4: res = a ^ b;
               5: res = w[30] ? word_t'($signed(a) >>> sh) : a >> sh;
               6: res = a | b;
               default: res = a & b;
            endcase
            mRegs[rd] = res;
         end
         7'b0000011: begin
            addr = a + iImm;
            lw = modelMem[addr[10:2]] >> (8 * addr[1:0]);
            case (f3)
               0: res = {{24{lw[7]}}, lw[7:0]};
               1: res = {{16{lw[15]}}, lw[15:0]};
               4: res = {24'b0, lw[7:0]};
               5: res = {16'b0, lw[15:0]};
               default: res = lw;
            endcase
            mRegs[rd] = res;
            loadAddrExp = addr;
            loadPending = 1'b1;
         end
         7'b0100011: begin
            addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
            storeAddrExp = addr;
            storeDataExp = (f3 == 0) ? {4{b[7:0]}} : (f3 == 1) ? {2{b[15:0]}} : b;
            storeMaskExp = (f3 == 0) ? 4'b0001 << addr[1:0]
                         : (f3 == 1) ? (addr[1] ? 4'b1100 : 4'b0011) : 4'b1111;
            for (int k = 0; k < 4; k++) begin
               if (storeMaskExp[k]) modelMem[addr[10:2]][8*k +: 8] = storeDataExp[8*k +: 8];
            end
            storePending = 1'b1;
         end
         default: ;                                          // SYSTEM
      endcase
      mRegs[0] = '0;
      mPc = nextPc;
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Bus monitor and memory model, outputs sampled and inputs driven on the falling edge
   always @(negedge clk) begin
      if (reset && !done) begin
         if (memWmask != 4'b0000) begin
            if (!storePending) reportFail("core wrote memory where no store was expected");
            checkEq("memAddr", memAddr, storeAddrExp);
            checkEq("memWdata", memWdata, storeDataExp);
            checkEq("memWmask", memWmask, storeMaskExp);
            storePending = 1'b0;
         end
         if (memRstrb) begin
            if (loadPending) begin
               checkEq("memAddr", memAddr, loadAddrExp);
               loadPending = 1'b0;
            end else begin
               if (storePending) reportFail("an expected store never happened");
               checkEq("memAddr", memAddr, mPc);                // Fetch address
               if (mPc == endPc) done = 1'b1;
               else stepModel();
            end
         end
      end
      if (memRstrb) begin
         if (memAddr >= memWords * 4) reportFail("read outside the memory model");
         memRdata = tbMem[memAddr[10:2]];
         rdLeft = rnd() % 4;
         memRbusy = rdLeft != 0;
      end else if (rdLeft > 0) begin
         rdLeft--;
         memRbusy = rdLeft != 0;
      end
      if (memWmask != 4'b0000) begin
         for (int k = 0; k < 4; k++) begin
            if (memWmask[k]) tbMem[memAddr[10:2]][8*k +: 8] = memWdata[8*k +: 8];
         end
         wrLeft = rnd() % 4;
         memWbusy = wrLeft != 0;
      end else if (wrLeft > 0) begin
         wrLeft--;
         memWbusy = wrLeft != 0;
      end
   end

   initial begin
      int cycles;
      reset = 1'b0;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      lcgState = 32'h4d89;
      rdLeft = 0;
      wrLeft = 0;
      done = 1'b0;
      loadPending = 1'b0;
      storePending = 1'b0;
      mPc = word_t'(resetAddr);
      for (int r = 0; r < 32; r++) mRegs[r] = '0;
      buildProgram();
      repeat (5) begin
         @(negedge clk);
         checkEq("memRstrb", memRstrb, 0);   // Quiet bus while in reset
         checkEq("memWmask", memWmask, 0);
      end
      reset = 1'b1;
      cycles = 0;
      while (!done && cycles < 20000) begin
         @(negedge clk);
         cycles++;
      end
      if (!done) reportFail("timeout waiting for the core to reach the final loop");
      for (int i = dataBase; i < memWords; i++) begin
         checkEq($sformatf("mem[%0d]", i), tbMem[i], modelMem[i]);
      end
      $display("Simulation PASSED");
      $finish;
   end

endmodule

/* verilog.f */
femtoPkg.sv
execIf.sv
regFile.sv
aluUnit.sv
loadStore.sv
coreControl.sv
femtoCore.sv
tbFemtoCore.sv
